//--- verilog/rename_defs.svh
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// Micro-ops renamed per cycle
`define WIDTH_UOPS 2

// Writeback result ports
`define WIDTH_WR 1

// Architectural and physical register space
`define NUM_AREGS 32
`define NUM_TAGS 64

`define TAG_BITS 6

// ROB sequence number width
`define SQN_BITS 6

`endif

//--- verilog/RenamePkg.sv
`include "rename_defs.svh"

package RenamePkg;

    typedef enum logic [1:0] {
        FU_INT,
        FU_LSU,
        FU_BRANCH,
        FU_MUL
    } FuType;

    // Micro-op as delivered by the decoder
    typedef struct packed {
        logic valid;
        logic [4:0] rs0;
        logic [4:0] rs1;
        logic [4:0] rd;
        FuType fu;
        logic [5:0] opcode;
        logic [31:0] imm;
        logic [31:0] pc;
    } DecodedUop;

    typedef struct packed {
        logic valid;
        logic [4:0] archDst;
        logic [`TAG_BITS-1:0] tagDst;
        logic [`SQN_BITS-1:0] sqN;
    } CommitUop;

    typedef struct packed {
        logic valid;
        logic [`TAG_BITS-1:0] tag;
    } WbResult;

    // Renamed micro-op handed to dispatch
    typedef struct packed {
        logic [4:0] rd;
        FuType fu;
        logic [5:0] opcode;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [`SQN_BITS-1:0] sqN;
        logic [`TAG_BITS-1:0] tagA;
        logic [`TAG_BITS-1:0] tagB;
        logic availA;
        logic availB;
        logic [`TAG_BITS-1:0] tagDst;
    } RenamedUop;

    typedef struct packed {
        logic [`TAG_BITS-1:0] tag;
        logic avail;
    } LookupResult;

endpackage

//--- verilog/RenameTable.sv
`include "rename_defs.svh"

module RenameTable
    import RenamePkg::*;
(
    input logic clk,
    input logic rst,
    input logic mispred,

    input logic [2*`WIDTH_UOPS-1:0][4:0] lookupIds,
    output LookupResult [2*`WIDTH_UOPS-1:0] lookup,

    input logic [`WIDTH_UOPS-1:0] issueValid,
    input logic [`WIDTH_UOPS-1:0][4:0] issueIds,
    input logic [`WIDTH_UOPS-1:0][`TAG_BITS-1:0] issueTags,

    input logic [`WIDTH_UOPS-1:0] commitValid,
    input logic [`WIDTH_UOPS-1:0][4:0] commitIds,
    input logic [`WIDTH_UOPS-1:0][`TAG_BITS-1:0] commitTags,
    output logic [`WIDTH_UOPS-1:0][`TAG_BITS-1:0] commitPrevTags,

    input WbResult [`WIDTH_WR-1:0] wb
);

    logic [`TAG_BITS-1:0] specTag [`NUM_AREGS];
    logic specAvail [`NUM_AREGS];
    logic [`TAG_BITS-1:0] comTag [`NUM_AREGS];

    // Committed map after this cycle's commits
    logic [`TAG_BITS-1:0] comNext [`NUM_AREGS];

    // Lookups with same-cycle writeback forwarding
    always_comb begin
        for (int k = 0; k < 2*`WIDTH_UOPS; k++) begin
            if (lookupIds[k] == 5'd0) begin
                lookup[k].tag = '0;
                lookup[k].avail = 1'b1;
            end else begin
                lookup[k].tag = specTag[lookupIds[k]];
                lookup[k].avail = specAvail[lookupIds[k]];
                for (int w = 0; w < `WIDTH_WR; w++) begin
                    if (wb[w].valid && wb[w].tag == specTag[lookupIds[k]])
                        lookup[k].avail = 1'b1;
                end
            end
        end
    end

    // A later slot sees the tag written by an earlier one
    always_comb begin
        for (int r = 0; r < `NUM_AREGS; r++)
            comNext[r] = comTag[r];
        for (int i = 0; i < `WIDTH_UOPS; i++) begin
            commitPrevTags[i] = comNext[commitIds[i]];
            if (commitValid[i] && commitIds[i] != 5'd0)
                comNext[commitIds[i]] = commitTags[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `NUM_AREGS; r++) begin
                specTag[r] <= `TAG_BITS'(r);
                specAvail[r] <= 1'b1;
                comTag[r] <= `TAG_BITS'(r);
            end
        end else begin
            for (int r = 0; r < `NUM_AREGS; r++)
                comTag[r] <= comNext[r];

            if (mispred) begin
                for (int r = 0; r < `NUM_AREGS; r++) begin
                    specTag[r] <= comNext[r];
                    specAvail[r] <= 1'b1;
                end
            end else begin
                for (int w = 0; w < `WIDTH_WR; w++) begin
                    if (wb[w].valid) begin
                        for (int r = 0; r < `NUM_AREGS; r++) begin
                            if (specTag[r] == wb[w].tag)
                                specAvail[r] <= 1'b1;
                        end
                    end
                end

                // Younger slot wins on a shared rd
                for (int i = 0; i < `WIDTH_UOPS; i++) begin
                    if (issueValid[i] && issueIds[i] != 5'd0) begin
                        specTag[issueIds[i]] <= issueTags[i];
                        specAvail[issueIds[i]] <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

//--- verilog/TagBuffer.sv
`include "rename_defs.svh"

module TagBuffer (
    input logic clk,
    input logic rst,
    input logic mispred,

    input logic [`WIDTH_UOPS-1:0] issueValid,
    output logic [`WIDTH_UOPS-1:0][`TAG_BITS-1:0] issueTags,

    input logic [`WIDTH_UOPS-1:0] commitValid,
    input logic [`WIDTH_UOPS-1:0][`TAG_BITS-1:0] freeTags,

    output logic [`TAG_BITS:0] freeCount
);

    // Extra wrap bit on every pointer
    localparam int PtrBits = `TAG_BITS + 1;

    logic [`TAG_BITS-1:0] list [`NUM_TAGS];

    logic [`TAG_BITS:0] tail;
    logic [`TAG_BITS:0] specHead;
    logic [`TAG_BITS:0] comHead;

    logic [`TAG_BITS:0] popCnt;
    logic [`TAG_BITS:0] pushCnt;
    logic [`WIDTH_UOPS-1:0][`TAG_BITS-1:0] popAddr;
    logic [`WIDTH_UOPS-1:0][`TAG_BITS-1:0] pushAddr;

    // Pops in slot order from the speculative head
    always_comb begin
        popCnt = '0;
        for (int i = 0; i < `WIDTH_UOPS; i++) begin
            popAddr[i] = specHead[`TAG_BITS-1:0] + popCnt[`TAG_BITS-1:0];
            issueTags[i] = list[popAddr[i]];
            if (issueValid[i])
                popCnt = popCnt + 1'b1;
        end
    end

    // Freed tags go to the tail in slot order
    always_comb begin
        pushCnt = '0;
        for (int i = 0; i < `WIDTH_UOPS; i++) begin
            pushAddr[i] = tail[`TAG_BITS-1:0] + pushCnt[`TAG_BITS-1:0];
            if (commitValid[i])
                pushCnt = pushCnt + 1'b1;
        end
    end

    assign freeCount = tail - specHead;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_TAGS - `NUM_AREGS; i++)
                list[i] <= `TAG_BITS'(i + `NUM_AREGS);
        end else begin
            for (int i = 0; i < `WIDTH_UOPS; i++) begin
                if (commitValid[i])
                    list[pushAddr[i]] <= freeTags[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tail <= PtrBits'(`NUM_TAGS - `NUM_AREGS);
            specHead <= '0;
            comHead <= '0;
        end else begin
            tail <= tail + pushCnt;
            // One committed allocation per valid commit
            comHead <= comHead + pushCnt;
            if (mispred)
                specHead <= comHead + pushCnt;
            else
                specHead <= specHead + popCnt;
        end
    end

endmodule

//--- verilog/Rename.sv
`include "rename_defs.svh"

module Rename
    import RenamePkg::*;
(
    input logic clk,
    input logic rst,
    input logic en,

    input DecodedUop [`WIDTH_UOPS-1:0] uop,
    input CommitUop [`WIDTH_UOPS-1:0] comUop,
    input WbResult [`WIDTH_WR-1:0] wb,

    input logic branchTaken,
    input logic [`SQN_BITS-1:0] branchSqN,

    output logic stall,
    output logic [`WIDTH_UOPS-1:0] uopValid,
    output RenamedUop [`WIDTH_UOPS-1:0] outUop,
    output logic [`SQN_BITS-1:0] nextSqN
);

    logic accept;
    logic [`TAG_BITS:0] needTags;
    logic [`TAG_BITS:0] freeCount;

    logic [`WIDTH_UOPS-1:0] issueValid;
    logic [`WIDTH_UOPS-1:0] tagReq;
    logic [`WIDTH_UOPS-1:0][4:0] issueIds;
    logic [`WIDTH_UOPS-1:0][`TAG_BITS-1:0] newTags;
    logic [`WIDTH_UOPS-1:0][`SQN_BITS-1:0] issueSqN;
    logic [`SQN_BITS-1:0] sqnAfter;

    logic [2*`WIDTH_UOPS-1:0][4:0] lookupIds;
    LookupResult [2*`WIDTH_UOPS-1:0] lookup;

    logic [`WIDTH_UOPS-1:0] commitValid;
    logic [`WIDTH_UOPS-1:0][4:0] commitIds;
    logic [`WIDTH_UOPS-1:0][`TAG_BITS-1:0] commitTags;
    logic [`WIDTH_UOPS-1:0][`TAG_BITS-1:0] commitPrevTags;
    logic signed [`SQN_BITS-1:0] commitAge [`WIDTH_UOPS];

    RenamedUop [`WIDTH_UOPS-1:0] renamed;

    // Tags the current group would consume
    always_comb begin
        needTags = '0;
        for (int i = 0; i < `WIDTH_UOPS; i++) begin
            if (uop[i].valid && uop[i].rd != 5'd0)
                needTags = needTags + 1'b1;
        end
    end

    assign stall = needTags > freeCount;
    assign accept = en && !stall && !branchTaken;

    always_comb begin
        sqnAfter = nextSqN;
        for (int i = 0; i < `WIDTH_UOPS; i++) begin
            issueValid[i] = accept && uop[i].valid;
            tagReq[i] = issueValid[i] && uop[i].rd != 5'd0;
            issueIds[i] = uop[i].rd;
            lookupIds[2*i] = uop[i].rs0;
            lookupIds[2*i+1] = uop[i].rs1;
            issueSqN[i] = sqnAfter;
            if (uop[i].valid)
                sqnAfter = sqnAfter + 1'b1;
        end
    end

    // Commits younger than a taken branch are dropped
    always_comb begin
        for (int i = 0; i < `WIDTH_UOPS; i++) begin
            commitAge[i] = $signed(comUop[i].sqN - branchSqN);
            commitValid[i] = comUop[i].valid && comUop[i].archDst != 5'd0 &&
                (!branchTaken || commitAge[i] <= 0);
            commitIds[i] = comUop[i].archDst;
            commitTags[i] = comUop[i].tagDst;
        end
    end

    RenameTable rt (
        .clk(clk),
        .rst(rst),
        .mispred(branchTaken),
        .lookupIds(lookupIds),
        .lookup(lookup),
        .issueValid(issueValid),
        .issueIds(issueIds),
        .issueTags(newTags),
        .commitValid(commitValid),
        .commitIds(commitIds),
        .commitTags(commitTags),
        .commitPrevTags(commitPrevTags),
        .wb(wb)
    );

    TagBuffer tb (
        .clk(clk),
        .rst(rst),
        .mispred(branchTaken),
        .issueValid(tagReq),
        .issueTags(newTags),
        .commitValid(commitValid),
        .freeTags(commitPrevTags),
        .freeCount(freeCount)
    );

    // Source bypass from older slots of the same group
    always_comb begin
        for (int i = 0; i < `WIDTH_UOPS; i++) begin
            renamed[i].rd = uop[i].rd;
            renamed[i].fu = uop[i].fu;
            renamed[i].opcode = uop[i].opcode;
            renamed[i].imm = uop[i].imm;
            renamed[i].pc = uop[i].pc;
            renamed[i].sqN = issueSqN[i];
            renamed[i].tagA = lookup[2*i].tag;
            renamed[i].availA = lookup[2*i].avail;
            renamed[i].tagB = lookup[2*i+1].tag;
            renamed[i].availB = lookup[2*i+1].avail;
            // Youngest older producer wins
            for (int j = 0; j < i; j++) begin
                if (tagReq[j] && uop[j].rd == uop[i].rs0) begin
                    renamed[i].tagA = newTags[j];
                    renamed[i].availA = 1'b0;
                end
                if (tagReq[j] && uop[j].rd == uop[i].rs1) begin
                    renamed[i].tagB = newTags[j];
                    renamed[i].availB = 1'b0;
                end
            end
            renamed[i].tagDst = tagReq[i] ? newTags[i] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            uopValid <= '0;
            nextSqN <= '0;
        end else if (branchTaken) begin
            uopValid <= '0;
            nextSqN <= branchSqN + 1'b1;
        end else if (accept) begin
            for (int i = 0; i < `WIDTH_UOPS; i++)
                uopValid[i] <= uop[i].valid;
            nextSqN <= sqnAfter;
        end else begin
            uopValid <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < `WIDTH_UOPS; i++)
                outUop[i] <= renamed[i];
        end
    end

endmodule

//--- verification/Rename_assert.sv
`include "rename_defs.svh"

module RenameAssert
    import RenamePkg::*;
(
    input logic clk,
    input logic rst,
    input DecodedUop [`WIDTH_UOPS-1:0] uop,
    input logic branchTaken,
    input logic stall,
    input logic [`WIDTH_UOPS-1:0] uopValid,
    input RenamedUop [`WIDTH_UOPS-1:0] outUop
);

    int failCount = 0;
    logic anyValid;

    always_comb begin
        anyValid = 1'b0;
        for (int i = 0; i < `WIDTH_UOPS; i++)
            anyValid = anyValid | uop[i].valid;
    end

    // An empty group needs no tags
    stallNeedsUops: assert property (@(posedge clk) disable iff (rst) !anyValid |-> !stall)
        else begin
            $error("stall is high while no slot is valid");
            failCount++;
        end

    quietAfterBranch: assert property (@(posedge clk) disable iff (rst)
        branchTaken |=> uopValid == '0)
        else begin
            $error("uopValid is high in the cycle after a taken branch");
            failCount++;
        end

    for (genvar i = 0; i < `WIDTH_UOPS; i++) begin : slotChecks
        destTagSet: assert property (@(posedge clk) disable iff (rst)
            uopValid[i] && outUop[i].rd != 5'd0 |-> outUop[i].tagDst != '0)
            else begin
                $error("slot %0d has tagDst 0 with a nonzero rd", i);
                failCount++;
            end
    end

    quietAfterReset: assert property (@(posedge clk) rst |=> uopValid == '0)
        else begin
            $error("uopValid is high in the cycle after reset");
            failCount++;
        end

endmodule

bind Rename RenameAssert renameAssert_i (.*);

//--- verification/RenameTb.sv
`include "rename_defs.svh"

module RenameTb
    import RenamePkg::*;
();

    localparam int ResetCycles = 16;
    localparam int TestCycles = 2000;
    localparam int CycleLimit = ResetCycles + TestCycles + 200;

    typedef struct packed {
        logic [4:0] rd;
        logic [`TAG_BITS-1:0] tag;
        logic [`SQN_BITS-1:0] sqN;
    } InFlight;

    logic clk;
    logic rst;
    logic en;
    DecodedUop [`WIDTH_UOPS-1:0] uop;
    CommitUop [`WIDTH_UOPS-1:0] comUop;
    WbResult [`WIDTH_WR-1:0] wb;
    logic branchTaken;
    logic [`SQN_BITS-1:0] branchSqN;
    logic stall;
    logic [`WIDTH_UOPS-1:0] uopValid;
    RenamedUop [`WIDTH_UOPS-1:0] outUop;
    logic [`SQN_BITS-1:0] nextSqN;

    integer seed = 32'hf7b896ef;
    int cycles = 0;
    int brIdx = 0;
    bit checking = 1'b0;
    bit lastAcc = 1'b1;

    // Reference model state
    logic [`TAG_BITS-1:0] specMap [`NUM_AREGS];
    bit specRdy [`NUM_AREGS];
    logic [`TAG_BITS-1:0] comMap [`NUM_AREGS];
    logic [`TAG_BITS-1:0] freeQ [$];
    int specOff;
    logic [`SQN_BITS-1:0] sqn;
    InFlight inflight [$];

    bit expStall;
    logic [`WIDTH_UOPS-1:0] expValid;
    RenamedUop [`WIDTH_UOPS-1:0] expUop;
    logic [`SQN_BITS-1:0] expSqN;
    logic [`WIDTH_UOPS-1:0] pendValid = '0;
    RenamedUop [`WIDTH_UOPS-1:0] pendUop;
    logic [`SQN_BITS-1:0] pendSqN = '0;

    Rename Rename_i (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic checkValue(input string name, input logic [127:0] expVal,
                              input logic [127:0] actVal);
        if (actVal !== expVal) begin
            $display("FAIL time %0t %s expected %0h actual %0h", $time, name, expVal, actVal);
            $display("Finished with errors");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic int randBelow(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Mostly low registers so that groups depend on each other
    function automatic logic [4:0] pickReg();
        if (randBelow(4) != 0)
            return 5'(randBelow(8));
        return 5'(randBelow(32));
    endfunction

    function automatic void resetModel();
        for (int r = 0; r < `NUM_AREGS; r++) begin
            specMap[r] = `TAG_BITS'(r);
            specRdy[r] = 1'b1;
            comMap[r] = `TAG_BITS'(r);
        end
        freeQ.delete();
        for (int t = `NUM_AREGS; t < `NUM_TAGS; t++)
            freeQ.push_back(`TAG_BITS'(t));
        specOff = 0;
        sqn = '0;
        inflight.delete();
    endfunction

    // Expected stall and renamed group plus the state after the next edge
    function automatic void renameModel();
        int need;
        int popped;
        bit acc;
        bit srcRdy;
        logic [4:0] src;
        logic [`TAG_BITS-1:0] srcTag;
        logic [`TAG_BITS-1:0] prev;
        logic [`SQN_BITS-1:0] seqNo;
        logic [`TAG_BITS-1:0] newTag [`WIDTH_UOPS];
        need = 0;
        for (int i = 0; i < `WIDTH_UOPS; i++)
            if (uop[i].valid && uop[i].rd != 5'd0)
                need++;
        expStall = need > (freeQ.size() - specOff);
        acc = en && !expStall && !branchTaken;
        expValid = '0;
        popped = 0;
        seqNo = sqn;
        for (int i = 0; i < `WIDTH_UOPS; i++) begin
            newTag[i] = '0;
            if (acc && uop[i].valid) begin
                expValid[i] = 1'b1;
                expUop[i] = '0;
                expUop[i].rd = uop[i].rd;
                expUop[i].fu = uop[i].fu;
                expUop[i].opcode = uop[i].opcode;
                expUop[i].imm = uop[i].imm;
                expUop[i].pc = uop[i].pc;
                expUop[i].sqN = seqNo;
                seqNo++;
                if (uop[i].rd != 5'd0) begin
                    newTag[i] = freeQ[specOff + popped];
                    popped++;
                end
                expUop[i].tagDst = newTag[i];
                for (int k = 0; k < 2; k++) begin
                    src = (k == 0) ? uop[i].rs0 : uop[i].rs1;
                    srcTag = specMap[src];
                    srcRdy = specRdy[src];
                    for (int w = 0; w < `WIDTH_WR; w++)
                        if (wb[w].valid && wb[w].tag == specMap[src])
                            srcRdy = 1'b1;
                    // Later older slots override earlier ones
                    for (int j = 0; j < i; j++)
                        if (uop[j].valid && uop[j].rd == src && src != 5'd0) begin
                            srcTag = newTag[j];
                            srcRdy = 1'b0;
                        end
                    if (k == 0) begin
                        expUop[i].tagA = srcTag;
                        expUop[i].availA = srcRdy;
                    end else begin
                        expUop[i].tagB = srcTag;
                        expUop[i].availB = srcRdy;
                    end
                end
            end
        end
        specOff += popped;
        for (int i = 0; i < `WIDTH_UOPS; i++) begin
            if (comUop[i].valid && comUop[i].archDst != 5'd0 && (!branchTaken || i <= brIdx)) begin
                prev = comMap[comUop[i].archDst];
                comMap[comUop[i].archDst] = comUop[i].tagDst;
                void'(freeQ.pop_front());
                freeQ.push_back(prev);
                specOff--;
            end
        end
        for (int i = 0; i < `WIDTH_UOPS; i++)
            if (comUop[i].valid)
                void'(inflight.pop_front());
        if (branchTaken) begin
            for (int r = 0; r < `NUM_AREGS; r++) begin
                specMap[r] = comMap[r];
                specRdy[r] = 1'b1;
            end
            specOff = 0;
            sqn = branchSqN + 1'b1;
            inflight.delete();
        end else begin
            for (int w = 0; w < `WIDTH_WR; w++)
                for (int r = 0; r < `NUM_AREGS; r++)
                    if (wb[w].valid && specMap[r] == wb[w].tag)
                        specRdy[r] = 1'b1;
            for (int i = 0; i < `WIDTH_UOPS; i++) begin
                if (expValid[i]) begin
                    if (uop[i].rd != 5'd0) begin
                        specMap[uop[i].rd] = newTag[i];
                        specRdy[uop[i].rd] = 1'b0;
                    end
                    inflight.push_back('{uop[i].rd, newTag[i], expUop[i].sqN});
                end
            end
            sqn = seqNo;
        end
        expSqN = sqn;
        lastAcc = acc;
    endfunction

    // Commits are slow in the first half of each phase so tags run out
    task automatic driveInputs(input int c);
        int nCom;
        int pick;
        bit slowCommit;
        slowCommit = (c % 500) < 250;
        if (lastAcc) begin
            for (int i = 0; i < `WIDTH_UOPS; i++) begin
                uop[i].valid = randBelow(8) != 0;
                uop[i].rs0 = pickReg();
                uop[i].rs1 = pickReg();
                uop[i].rd = pickReg();
                uop[i].fu = FuType'(randBelow(4));
                uop[i].opcode = 6'(randBelow(64));
                uop[i].imm = $random(seed);
                uop[i].pc = 32'h1000 + 8 * c + 4 * i;
            end
        end
        en = randBelow(4) != 0;
        branchTaken = 1'b0;
        branchSqN = '0;
        brIdx = 0;
        comUop = '0;
        wb = '0;
        if (slowCommit)
            nCom = (randBelow(8) == 0) ? 1 : 0;
        else
            nCom = (randBelow(4) == 0) ? 1 : 2;
        if (inflight.size() > 0 && randBelow(slowCommit ? 200 : 40) == 0) begin
            branchTaken = 1'b1;
            nCom = 2;
            brIdx = randBelow(inflight.size() < 2 ? 1 : 2);
            branchSqN = inflight[brIdx].sqN;
        end
        if (nCom > inflight.size())
            nCom = inflight.size();
        for (int i = 0; i < nCom; i++) begin
            comUop[i].valid = 1'b1;
            comUop[i].archDst = inflight[i].rd;
            comUop[i].tagDst = inflight[i].tag;
            comUop[i].sqN = inflight[i].sqN;
        end
        if (inflight.size() > 0 && randBelow(2) == 0) begin
            pick = randBelow(inflight.size());
            wb[0].valid = inflight[pick].rd != 5'd0;
            wb[0].tag = inflight[pick].tag;
        end
    endtask

    always @(posedge clk) begin : compareOutputs
        string pre;
        if (checking) begin
            checkValue("stall", expStall, stall);
            checkValue("uopValid", pendValid, uopValid);
            checkValue("nextSqN", pendSqN, nextSqN);
            for (int i = 0; i < `WIDTH_UOPS; i++) begin
                pre = $sformatf("outUop[%0d].", i);
                if (pendValid[i]) begin
                    checkValue({pre, "rd"}, pendUop[i].rd, outUop[i].rd);
                    checkValue({pre, "fu"}, pendUop[i].fu, outUop[i].fu);
                    checkValue({pre, "opcode"}, pendUop[i].opcode, outUop[i].opcode);
                    checkValue({pre, "imm"}, pendUop[i].imm, outUop[i].imm);
                    checkValue({pre, "pc"}, pendUop[i].pc, outUop[i].pc);
                    checkValue({pre, "sqN"}, pendUop[i].sqN, outUop[i].sqN);
                    checkValue({pre, "tagA"}, pendUop[i].tagA, outUop[i].tagA);
                    checkValue({pre, "availA"}, pendUop[i].availA, outUop[i].availA);
                    checkValue({pre, "tagB"}, pendUop[i].tagB, outUop[i].tagB);
                    checkValue({pre, "availB"}, pendUop[i].availB, outUop[i].availB);
                    checkValue({pre, "tagDst"}, pendUop[i].tagDst, outUop[i].tagDst);
                end
            end
            pendValid = expValid;
            pendUop = expUop;
            pendSqN = expSqN;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("Finished with errors");
            $fatal(1, "Timeout");
        end else if (Rename_i.renameAssert_i.failCount != 0) begin
            $display("An assertion on the DUT failed");
            $display("Finished with errors");
            $fatal(1, "Assertion failure");
        end
    end

    initial begin
        rst = 1'b1;
        en = 1'b0;
        uop = '0;
        comUop = '0;
        wb = '0;
        branchTaken = 1'b0;
        branchSqN = '0;
        resetModel();
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int c = 0; c < TestCycles; c++) begin
            driveInputs(c);
            renameModel();
            checking = 1'b1;
            @(negedge clk);
        end
        // One idle cycle so the last group is compared
        en = 1'b0;
        comUop = '0;
        wb = '0;
        branchTaken = 1'b0;
        renameModel();
        @(posedge clk);
        @(negedge clk);
        if (Rename_i.renameAssert_i.failCount != 0) begin
            $display("Assertions failed %0d times", Rename_i.renameAssert_i.failCount);
            $display("Finished with errors");
            $fatal(1, "Assertion failures");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

//--- Rename.f
+incdir+verilog
verilog/RenamePkg.sv
verilog/RenameTable.sv
verilog/TagBuffer.sv
verilog/Rename.sv
verification/Rename_assert.sv
verification/RenameTb.sv

//--- Bender.yml
package:
  name: rename

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/RenamePkg.sv
      - verilog/RenameTable.sv
      - verilog/TagBuffer.sv
      - verilog/Rename.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/Rename_assert.sv
      - verification/RenameTb.sv
